//--- core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data and address width
`define CORE_XLEN 64

// instruction width
`define CORE_ILEN 32

// register address width for 32 registers
`define CORE_REG_AW 5

`define CORE_RESET_PC 64'h0000_0000_0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

//--- core_pkg.sv
`default_nettype none
`include "core_macros.svh"

package core_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JUMP} br_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    // all-zero value is a bubble
    typedef struct packed {
        logic    reg_we;
        logic    mem_read;
        logic    mem_write;
        logic    b_is_imm;
        alu_op_e alu_op;
        br_op_e  br_op;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic                    we;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
    } bypass_t;

    typedef struct packed {
        logic                  taken;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

//--- hazard_if.sv
`timescale 1ns/1ps
`default_nettype none

interface hazard_if;

    // pc and IF/ID
    logic stall_if;
    logic flush_id;
    // ID/EX
    logic stall_id;
    logic flush_ex;
    // EX/MEM and MEM/WB
    logic stall_ex;
    logic stall_mem;

    modport hazard (output stall_if, stall_id, flush_id, flush_ex, stall_ex, stall_mem);
    modport fetch (input stall_if, flush_id);
    modport decode (input stall_id, flush_ex);
    modport execute (input stall_ex);
    modport memory (input stall_mem);

endinterface

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst,
    hazard_if.fetch               hz,
    input  core_pkg::redirect_t   redirect,
    output logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_ILEN-1:0] inst,
    output logic                  id_valid,
    output logic [`CORE_XLEN-1:0] id_pc,
    output logic [`CORE_ILEN-1:0] id_inst
);
    logic [`CORE_XLEN-1:0] pc_next;

    // always predict fall-through, execute corrects it
    assign pc_next = redirect.taken ? redirect.target : pc + 'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_PC;
        end else if (!hz.stall_if) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            id_inst  <= `CORE_NOP;
        end else if (hz.flush_id) begin
            id_valid <= 1'b0;
            id_inst  <= `CORE_NOP;
        end else if (!hz.stall_if) begin
            id_valid <= 1'b1;
            id_pc    <= pc;
            id_inst  <= inst;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    hazard_if.decode                hz,
    input  logic                    id_valid,
    input  logic [`CORE_XLEN-1:0]   id_pc,
    input  logic [`CORE_ILEN-1:0]   id_inst,
    input  core_pkg::bypass_t       ex_bypass,
    input  core_pkg::bypass_t       mem_bypass,
    input  core_pkg::bypass_t       wb_bypass,
    output logic [`CORE_REG_AW-1:0] id_rs1,
    output logic [`CORE_REG_AW-1:0] id_rs2,
    output logic                    ex_valid,
    output logic [`CORE_XLEN-1:0]   ex_pc,
    output core_pkg::ctrl_t         ex_ctrl,
    output logic [`CORE_XLEN-1:0]   ex_rs1_data,
    output logic [`CORE_XLEN-1:0]   ex_rs2_data,
    output logic [`CORE_XLEN-1:0]   ex_imm,
    output logic [`CORE_REG_AW-1:0] ex_rd
);
    logic [`CORE_XLEN-1:0]   regs [2**`CORE_REG_AW];
    core_pkg::ctrl_t         ctrl;
    logic [`CORE_XLEN-1:0]   imm;
    logic                    use_rs1;
    logic                    use_rs2;
    logic [`CORE_REG_AW-1:0] rd;

    assign rd = id_inst[11:7];
    // only real sources feed load-use detection
    assign id_rs1 = (id_valid && use_rs1) ? id_inst[19:15] : '0;
    assign id_rs2 = (id_valid && use_rs2) ? id_inst[24:20] : '0;

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (id_inst[6:0])
            core_pkg::OPC_OP: begin
                ctrl.reg_we = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                case ({id_inst[31:25], id_inst[14:12]})
                    {7'h00, 3'b000}: ctrl.alu_op = core_pkg::ALU_ADD;
                    {7'h20, 3'b000}: ctrl.alu_op = core_pkg::ALU_SUB;
                    {7'h00, 3'b111}: ctrl.alu_op = core_pkg::ALU_AND;
                    {7'h00, 3'b110}: ctrl.alu_op = core_pkg::ALU_OR;
                    {7'h00, 3'b100}: ctrl.alu_op = core_pkg::ALU_XOR;
                    {7'h00, 3'b010}: ctrl.alu_op = core_pkg::ALU_SLT;
                    default:         ctrl.reg_we = 1'b0;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                // addi only
                ctrl.reg_we   = (id_inst[14:12] == 3'b000);
                ctrl.b_is_imm = 1'b1;
                use_rs1       = 1'b1;
                imm           = {{(`CORE_XLEN-12){id_inst[31]}}, id_inst[31:20]};
            end
            core_pkg::OPC_LOAD: begin
                ctrl.reg_we   = (id_inst[14:12] == 3'b011);
                ctrl.mem_read = (id_inst[14:12] == 3'b011);
                ctrl.b_is_imm = 1'b1;
                ctrl.wb_sel   = core_pkg::WB_MEM;
                use_rs1       = 1'b1;
                imm           = {{(`CORE_XLEN-12){id_inst[31]}}, id_inst[31:20]};
            end
            core_pkg::OPC_STORE: begin
                ctrl.mem_write = (id_inst[14:12] == 3'b011);
                ctrl.b_is_imm  = 1'b1;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                imm = {{(`CORE_XLEN-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
            end
            core_pkg::OPC_BRANCH: begin
                if (id_inst[14:12] == 3'b000) begin
                    ctrl.br_op = core_pkg::BR_BEQ;
                end else if (id_inst[14:12] == 3'b001) begin
                    ctrl.br_op = core_pkg::BR_BNE;
                end
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = {{(`CORE_XLEN-13){id_inst[31]}}, id_inst[31], id_inst[7],
                       id_inst[30:25], id_inst[11:8], 1'b0};
            end
            core_pkg::OPC_JAL: begin
                ctrl.reg_we = 1'b1;
                ctrl.br_op  = core_pkg::BR_JUMP;
                ctrl.wb_sel = core_pkg::WB_PC4;
                imm = {{(`CORE_XLEN-21){id_inst[31]}}, id_inst[31], id_inst[19:12],
                       id_inst[20], id_inst[30:21], 1'b0};
            end
            default: ;
        endcase
        if (rd == '0) begin
            ctrl.reg_we = 1'b0;
        end
    end

    // youngest producer wins, x0 reads zero
    function automatic logic [`CORE_XLEN-1:0] read_src(input logic [`CORE_REG_AW-1:0] rs);
        if (rs == '0) return '0;
        if (ex_bypass.we && ex_bypass.rd == rs) return ex_bypass.data;
        if (mem_bypass.we && mem_bypass.rd == rs) return mem_bypass.data;
        if (wb_bypass.we && wb_bypass.rd == rs) return wb_bypass.data;
        return regs[rs];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_bypass.we && wb_bypass.rd != '0) begin
            regs[wb_bypass.rd] <= wb_bypass.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || hz.flush_ex) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
        end else if (!hz.stall_id) begin
            ex_valid    <= id_valid;
            ex_ctrl     <= id_valid ? ctrl : '0;
            ex_pc       <= id_pc;
            ex_rs1_data <= read_src(id_inst[19:15]);
            ex_rs2_data <= read_src(id_inst[24:20]);
            ex_imm      <= imm;
            ex_rd       <= rd;
        end
    end

    // writes to x0 are dropped before they reach writeback
    assert property (@(posedge clk) disable iff (rst) wb_bypass.we |-> wb_bypass.rd != '0);

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    hazard_if.execute               hz,
    input  logic                    ex_valid,
    input  logic [`CORE_XLEN-1:0]   ex_pc,
    input  core_pkg::ctrl_t         ex_ctrl,
    input  logic [`CORE_XLEN-1:0]   ex_rs1_data,
    input  logic [`CORE_XLEN-1:0]   ex_rs2_data,
    input  logic [`CORE_XLEN-1:0]   ex_imm,
    input  logic [`CORE_REG_AW-1:0] ex_rd,
    output core_pkg::redirect_t     redirect,
    output core_pkg::bypass_t       ex_bypass,
    output logic                    ex_is_load,
    output logic                    mem_valid,
    output core_pkg::ctrl_t         mem_ctrl,
    output logic [`CORE_XLEN-1:0]   mem_alu,
    output logic [`CORE_XLEN-1:0]   mem_store_data,
    output logic [`CORE_REG_AW-1:0] mem_rd,
    output logic [`CORE_XLEN-1:0]   mem_pc4
);
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [`CORE_XLEN-1:0] pc4;
    logic                  taken;

    assign alu_b = ex_ctrl.b_is_imm ? ex_imm : ex_rs2_data;
    assign pc4   = ex_pc + 'd4;

    always_comb begin
        case (ex_ctrl.alu_op)
            core_pkg::ALU_SUB: alu_res = ex_rs1_data - alu_b;
            core_pkg::ALU_AND: alu_res = ex_rs1_data & alu_b;
            core_pkg::ALU_OR:  alu_res = ex_rs1_data | alu_b;
            core_pkg::ALU_XOR: alu_res = ex_rs1_data ^ alu_b;
            core_pkg::ALU_SLT: alu_res = {{(`CORE_XLEN-1){1'b0}},
                                          $signed(ex_rs1_data) < $signed(alu_b)};
            default:           alu_res = ex_rs1_data + alu_b;
        endcase
    end

    always_comb begin
        case (ex_ctrl.br_op)
            core_pkg::BR_BEQ:  taken = (ex_rs1_data == ex_rs2_data);
            core_pkg::BR_BNE:  taken = (ex_rs1_data != ex_rs2_data);
            core_pkg::BR_JUMP: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    assign redirect.taken  = ex_valid && taken;
    assign redirect.target = ex_pc + ex_imm;

    // load data is not known yet, hazard unit stalls the consumer
    assign ex_is_load     = ex_valid && ex_ctrl.mem_read;
    assign ex_bypass.we   = ex_valid && ex_ctrl.reg_we;
    assign ex_bypass.rd   = ex_rd;
    assign ex_bypass.data = (ex_ctrl.wb_sel == core_pkg::WB_PC4) ? pc4 : alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
            mem_ctrl  <= '0;
        end else if (!hz.stall_ex) begin
            mem_valid      <= ex_valid;
            mem_ctrl       <= ex_ctrl;
            mem_alu        <= alu_res;
            mem_store_data <= ex_rs2_data;
            mem_rd         <= ex_rd;
            mem_pc4        <= pc4;
        end
    end

endmodule

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module memory_stage (
    input  logic                    clk,
    input  logic                    rst,
    hazard_if.memory                hz,
    input  logic                    mem_valid,
    input  core_pkg::ctrl_t         mem_ctrl,
    input  logic [`CORE_XLEN-1:0]   mem_alu,
    input  logic [`CORE_XLEN-1:0]   mem_store_data,
    input  logic [`CORE_REG_AW-1:0] mem_rd,
    input  logic [`CORE_XLEN-1:0]   mem_pc4,
    output logic [`CORE_XLEN-1:0]   dmem_addr,
    output logic                    dmem_we,
    output logic [`CORE_XLEN-1:0]   dmem_wdata,
    output logic                    dmem_re,
    input  logic [`CORE_XLEN-1:0]   dmem_rdata,
    input  logic                    mem_stall,
    output core_pkg::bypass_t       mem_bypass,
    output core_pkg::bypass_t       wb_bypass,
    output logic                    commit_valid,
    output logic [`CORE_XLEN-1:0]   commit_pc,
    output logic [`CORE_REG_AW-1:0] commit_rd,
    output logic                    commit_we,
    output logic [`CORE_XLEN-1:0]   commit_data
);
    logic [`CORE_XLEN-1:0] result;
    logic                  wb_valid;
    logic                  wb_we;

    // EX/MEM holds during mem_stall so these stay put
    assign dmem_addr  = mem_alu;
    assign dmem_wdata = mem_store_data;
    assign dmem_we    = mem_valid && mem_ctrl.mem_write;
    assign dmem_re    = mem_valid && mem_ctrl.mem_read;

    always_comb begin
        case (mem_ctrl.wb_sel)
            core_pkg::WB_MEM: result = dmem_rdata;
            core_pkg::WB_PC4: result = mem_pc4;
            default:          result = mem_alu;
        endcase
    end

    assign mem_bypass.we   = mem_valid && mem_ctrl.reg_we;
    assign mem_bypass.rd   = mem_rd;
    assign mem_bypass.data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else if (!hz.stall_mem) begin
            wb_valid    <= mem_valid;
            wb_we       <= mem_valid && mem_ctrl.reg_we;
            commit_rd   <= mem_rd;
            commit_data <= result;
            // commit pc recovered from pc+4
            commit_pc   <= mem_pc4 - 'd4;
        end
    end

    // a held WB entry retires once, in the cycle the stall drops
    assign commit_valid   = wb_valid && !mem_stall;
    assign commit_we      = wb_we && commit_valid;
    assign wb_bypass.we   = commit_we;
    assign wb_bypass.rd   = commit_rd;
    assign wb_bypass.data = commit_data;

    assert property (@(posedge clk) disable iff (rst) !(dmem_we && dmem_re));

endmodule

`default_nettype wire

//--- hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module hazard_unit (
    hazard_if.hazard                hz,
    input  logic [`CORE_REG_AW-1:0] id_rs1,
    input  logic [`CORE_REG_AW-1:0] id_rs2,
    input  logic                    ex_is_load,
    input  logic [`CORE_REG_AW-1:0] ex_rd,
    input  core_pkg::redirect_t     redirect,
    input  logic                    mem_stall
);
    logic load_use;
    logic hold_front;

    assign load_use = ex_is_load && (ex_rd != '0) && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // redirect wins over the load-use bubble
    assign hold_front = mem_stall || (load_use && !redirect.taken);

    assign hz.stall_if  = hold_front;
    assign hz.stall_id  = hold_front;
    assign hz.flush_id  = redirect.taken && !mem_stall;
    assign hz.flush_ex  = (redirect.taken || load_use) && !mem_stall;
    assign hz.stall_ex  = mem_stall;
    assign hz.stall_mem = mem_stall;

endmodule

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_top (
    input  logic                    clk,
    input  logic                    rst,
    output logic [`CORE_XLEN-1:0]   pc,
    input  logic [`CORE_ILEN-1:0]   inst,
    output logic [`CORE_XLEN-1:0]   dmem_addr,
    output logic                    dmem_we,
    output logic [`CORE_XLEN-1:0]   dmem_wdata,
    output logic                    dmem_re,
    input  logic [`CORE_XLEN-1:0]   dmem_rdata,
    input  logic                    mem_stall,
    output logic                    commit_valid,
    output logic [`CORE_XLEN-1:0]   commit_pc,
    output logic [`CORE_REG_AW-1:0] commit_rd,
    output logic                    commit_we,
    output logic [`CORE_XLEN-1:0]   commit_data
);
    logic                    id_valid;
    logic [`CORE_XLEN-1:0]   id_pc;
    logic [`CORE_ILEN-1:0]   id_inst;
    logic [`CORE_REG_AW-1:0] id_rs1;
    logic [`CORE_REG_AW-1:0] id_rs2;
    logic                    ex_valid;
    logic [`CORE_XLEN-1:0]   ex_pc;
    core_pkg::ctrl_t         ex_ctrl;
    logic [`CORE_XLEN-1:0]   ex_rs1_data;
    logic [`CORE_XLEN-1:0]   ex_rs2_data;
    logic [`CORE_XLEN-1:0]   ex_imm;
    logic [`CORE_REG_AW-1:0] ex_rd;
    core_pkg::redirect_t     redirect;
    core_pkg::bypass_t       ex_bypass;
    logic                    ex_is_load;
    logic                    mem_valid;
    core_pkg::ctrl_t         mem_ctrl;
    logic [`CORE_XLEN-1:0]   mem_alu;
    logic [`CORE_XLEN-1:0]   mem_store_data;
    logic [`CORE_REG_AW-1:0] mem_rd;
    logic [`CORE_XLEN-1:0]   mem_pc4;
    core_pkg::bypass_t       mem_bypass;
    core_pkg::bypass_t       wb_bypass;

    hazard_if hz ();

    fetch_stage u_fetch (.clk, .rst, .hz(hz.fetch), .redirect, .pc, .inst,
        .id_valid, .id_pc, .id_inst);

    decode_stage u_decode (.clk, .rst, .hz(hz.decode), .id_valid, .id_pc, .id_inst,
        .ex_bypass, .mem_bypass, .wb_bypass, .id_rs1, .id_rs2, .ex_valid, .ex_pc,
        .ex_ctrl, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rd);

    execute_stage u_execute (.clk, .rst, .hz(hz.execute), .ex_valid, .ex_pc, .ex_ctrl,
        .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rd, .redirect, .ex_bypass, .ex_is_load,
        .mem_valid, .mem_ctrl, .mem_alu, .mem_store_data, .mem_rd, .mem_pc4);

    memory_stage u_memory (.clk, .rst, .hz(hz.memory), .mem_valid, .mem_ctrl, .mem_alu,
        .mem_store_data, .mem_rd, .mem_pc4, .dmem_addr, .dmem_we, .dmem_wdata, .dmem_re,
        .dmem_rdata, .mem_stall, .mem_bypass, .wb_bypass, .commit_valid, .commit_pc,
        .commit_rd, .commit_we, .commit_data);

    hazard_unit u_hazard (.hz(hz.hazard), .id_rs1, .id_rs2, .ex_is_load, .ex_rd,
        .redirect, .mem_stall);

endmodule

`default_nettype wire

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module tb_core;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    we;
        logic [`CORE_XLEN-1:0]   data;
    } commit_rec_t;

    logic                    clk;
    logic                    rst;
    logic                    mem_stall;
    logic                    stall_en;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_ILEN-1:0]   inst;
    logic [`CORE_XLEN-1:0]   dmem_addr;
    logic                    dmem_we;
    logic [`CORE_XLEN-1:0]   dmem_wdata;
    logic                    dmem_re;
    logic [`CORE_XLEN-1:0]   dmem_rdata;
    logic                    commit_valid;
    logic [`CORE_XLEN-1:0]   commit_pc;
    logic [`CORE_REG_AW-1:0] commit_rd;
    logic                    commit_we;
    logic [`CORE_XLEN-1:0]   commit_data;

    logic [`CORE_ILEN-1:0] rom [256];
    logic [`CORE_XLEN-1:0] ram [256];
    logic [`CORE_XLEN-1:0] model_ram [256];
    commit_rec_t           exp_q [$];
    commit_rec_t           mon_rec;
    logic [`CORE_XLEN-1:0] halt_pc;
    int                    load_idx;
    int                    cycle_count = 0;
    int                    cycle_limit = 200;
    int                    total_commits = 0;
    bit                    stall_pat [1024];
    logic                  held_stall = 1'b0;
    logic [`CORE_XLEN*2+1:0] held_dmem;

    core_top UUT (.clk, .rst, .pc, .inst, .dmem_addr, .dmem_we, .dmem_wdata, .dmem_re,
        .dmem_rdata, .mem_stall, .commit_valid, .commit_pc, .commit_rd, .commit_we,
        .commit_data);

    // both memories answer in the same cycle
    assign inst       = rom[pc[9:2]];
    assign dmem_rdata = ram[dmem_addr[10:3]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (dmem_we && !mem_stall) begin
            ram[dmem_addr[10:3]] <= dmem_wdata;
        end
        mem_stall <= stall_en && stall_pat[cycle_count % 1024];
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout: run stopped after %0d cycles", cycle_count));
        end
    end

    // commits past the model's list may only come from the halt loop
    always @(posedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                assert (commit_pc == halt_pc && !commit_we)
                    else fail_run($sformatf("error at %0t: unexpected commit at pc %h",
                        $time, commit_pc));
            end else begin
                mon_rec = exp_q.pop_front();
                assert (commit_pc == mon_rec.pc && commit_we == mon_rec.we)
                    else fail_run($sformatf("error at %0t: commit pc %h we %b, expected %h %b",
                        $time, commit_pc, commit_we, mon_rec.pc, mon_rec.we));
                assert (!mon_rec.we || (commit_rd == mon_rec.rd && commit_data == mon_rec.data))
                    else fail_run($sformatf("error at %0t: pc %h wrote x%0d=%h, expected x%0d=%h",
                        $time, commit_pc, commit_rd, commit_data, mon_rec.rd, mon_rec.data));
            end
        end
    end

    // a stalled cycle must leave the data port untouched
    always @(posedge clk) begin
        if (!rst && held_stall) begin
            assert ({dmem_addr, dmem_wdata, dmem_we, dmem_re} === held_dmem)
                else fail_run($sformatf("error at %0t: dmem outputs changed during mem_stall",
                    $time));
        end
        held_stall <= mem_stall && !rst;
        held_dmem  <= {dmem_addr, dmem_wdata, dmem_we, dmem_re};
    end

    function automatic logic [31:0] addi_inst(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_inst(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] load_inst(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_inst(input logic [4:0] rs2, rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                                input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // initial data pattern built from the whole index
    function automatic logic [63:0] ram_fill(input int idx);
        return {32'(idx) * 32'h9e37_79b9, 32'hc0de_0000 | 32'(idx)};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[load_idx] = word;
        load_idx++;
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            rom[i]       = `CORE_NOP;
            ram[i]       = ram_fill(i);
            model_ram[i] = ram_fill(i);
        end
        load_idx = 0;
    endtask

    task automatic load_alu_program();
        emit(addi_inst(1, 0, 5));
        emit(addi_inst(2, 1, 7));
        emit(alu_inst(7'h00, 3'b000, 3, 1, 2));
        emit(alu_inst(7'h20, 3'b000, 4, 3, 1));
        emit(alu_inst(7'h00, 3'b100, 5, 4, 2));
        emit(alu_inst(7'h00, 3'b111, 6, 5, 3));
        emit(alu_inst(7'h00, 3'b110, 7, 6, 4));
        emit(alu_inst(7'h00, 3'b010, 8, 4, 7));
        emit(addi_inst(9, 0, -3));
        emit(alu_inst(7'h00, 3'b010, 10, 9, 1));
        // ori is outside the subset
        emit({12'd1, 5'd1, 3'b110, 5'd11, 7'b0010011});
        emit(alu_inst(7'h00, 3'b000, 0, 1, 2));
        emit(jal_inst(0, 0));
    endtask

    task automatic load_mem_program();
        emit(addi_inst(1, 0, 64));
        emit(addi_inst(2, 0, 123));
        emit(store_inst(2, 1, 0));
        emit(addi_inst(3, 0, -7));
        emit(store_inst(3, 1, 8));
        emit(load_inst(4, 1, 0));
        emit(alu_inst(7'h00, 3'b000, 5, 4, 4));
        emit(load_inst(6, 1, 8));
        emit(alu_inst(7'h20, 3'b000, 7, 6, 4));
        emit(load_inst(8, 0, 256));
        emit(alu_inst(7'h00, 3'b100, 9, 8, 2));
        emit(store_inst(9, 1, 16));
        emit(load_inst(10, 1, 16));
        emit(store_inst(10, 1, 24));
        emit(jal_inst(0, 0));
    endtask

    task automatic load_branch_program();
        emit(addi_inst(1, 0, 3));
        emit(addi_inst(2, 0, 3));
        emit(branch_inst(3'b000, 1, 2, 12));
        emit(addi_inst(3, 0, 111));
        emit(addi_inst(3, 0, 222));
        emit(branch_inst(3'b001, 1, 2, 8));
        emit(addi_inst(4, 0, 1));
        emit(branch_inst(3'b000, 4, 0, 8));
        emit(branch_inst(3'b001, 4, 0, 12));
        emit(addi_inst(5, 0, 5));
        emit(addi_inst(5, 0, 6));
        emit(jal_inst(6, 12));
        emit(addi_inst(7, 0, 9));
        emit(addi_inst(7, 0, 10));
        emit(alu_inst(7'h00, 3'b000, 8, 6, 4));
        // three passes through a backward loop
        emit(addi_inst(10, 0, 3));
        emit(addi_inst(11, 0, 0));
        emit(addi_inst(11, 11, 2));
        emit(addi_inst(10, 10, -1));
        emit(branch_inst(3'b001, 10, 0, -8));
        emit(branch_inst(3'b000, 0, 0, 8));
        emit(addi_inst(9, 0, 1));
        emit(jal_inst(0, 0));
    endtask

    // in-order ISA model that fills exp_q up to the self-jump
    task automatic run_model();
        logic [63:0] regs [32];
        logic [63:0] mpc;
        logic [63:0] nxt;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] res;
        logic [63:0] addr;
        logic [31:0] ins;
        logic        wr;
        commit_rec_t rec;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        mpc = `CORE_RESET_PC;
        for (int step = 0; step < 200; step++) begin
            ins = rom[mpc[9:2]];
            a   = regs[ins[19:15]];
            b   = regs[ins[24:20]];
            wr  = 1'b0;
            res = '0;
            nxt = mpc + 4;
            case (ins[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_111: res = a & b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        default:         wr = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    wr  = (ins[14:12] == 3'b000);
                    res = a + {{52{ins[31]}}, ins[31:20]};
                end
                7'b0000011: begin
                    wr   = (ins[14:12] == 3'b011);
                    addr = a + {{52{ins[31]}}, ins[31:20]};
                    res  = model_ram[addr[10:3]];
                end
                7'b0100011: begin
                    addr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
                    if (ins[14:12] == 3'b011) begin
                        model_ram[addr[10:3]] = b;
                    end
                end
                7'b1100011: begin
                    if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                        nxt = mpc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    wr  = 1'b1;
                    res = mpc + 4;
                    nxt = mpc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: ;
            endcase
            if (ins[11:7] == 5'd0) begin
                wr = 1'b0;
            end
            rec = '{pc: mpc, rd: ins[11:7], we: wr, data: res};
            exp_q.push_back(rec);
            if (wr) begin
                regs[ins[11:7]] = res;
            end
            if (nxt == mpc) begin
                break;
            end
            mpc = nxt;
        end
        halt_pc       = mpc;
        total_commits = total_commits + exp_q.size();
        cycle_limit   = 10 * total_commits + 200;
    endtask

    task automatic check_ram();
        for (int i = 0; i < 256; i++) begin
            assert (ram[i] == model_ram[i])
                else fail_run($sformatf("error at %0t: ram[%0d] = %h, expected %h",
                    $time, i, ram[i], model_ram[i]));
        end
    endtask

    task automatic run_program(input int prog, input bit stalls);
        @(posedge clk);
        rst      <= 1'b1;
        stall_en <= 1'b0;
        @(posedge clk);
        clear_memories();
        case (prog)
            0:       load_alu_program();
            1:       load_mem_program();
            default: load_branch_program();
        endcase
        run_model();
        repeat (7) @(posedge clk);
        rst      <= 1'b0;
        stall_en <= stalls;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        check_ram();
    endtask

    task automatic test_reset_state();
        @(posedge clk);
        repeat (7) begin
            @(posedge clk);
            assert (pc == `CORE_RESET_PC && !commit_valid && !dmem_we && !dmem_re)
                else fail_run($sformatf("error at %0t: core not in reset state", $time));
        end
        rst <= 1'b0;
        @(posedge clk);
        assert (pc == `CORE_RESET_PC && !commit_valid && !dmem_we && !dmem_re)
            else fail_run($sformatf("error at %0t: bad state leaving reset", $time));
    endtask

    task automatic test_alu_forwarding();
        run_program(0, 1'b0);
    endtask

    task automatic test_load_store();
        run_program(1, 1'b0);
    endtask

    task automatic test_branches();
        run_program(2, 1'b0);
    endtask

    // the memory program puts loads and stores under stall
    task automatic test_stall_rerun();
        run_program(0, 1'b1);
        run_program(1, 1'b1);
    endtask

    initial begin
        rst       = 1'b1;
        mem_stall = 1'b0;
        stall_en  = 1'b0;
        void'($urandom(70));
        for (int i = 0; i < 1024; i++) begin
            stall_pat[i] = ($urandom % 4) == 0;
        end
        clear_memories();
        // halt loop at the reset pc until the first program loads
        rom[0]  = jal_inst(0, 0);
        halt_pc = `CORE_RESET_PC;
        test_reset_state();
        test_alu_forwarding();
        test_load_store();
        test_branches();
        test_stall_rerun();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
core_pkg.sv
hazard_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
core_top.sv
tb_core.sv

//--- Bender.yml
package:
  name: rv64_core

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - hazard_if.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - hazard_unit.sv
  - core_top.sv
  - target: test
    files:
      - tb_core.sv
